// ==== uart_consts.svh ====
// bus widths, register offsets, response codes and FIFO depth
// for the UART register interface
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// bus widths
`define UART_ADDR_W 5
`define UART_DATA_W 32

// default FIFO depth
`define UART_FIFO_DEPTH 16

// register offsets
`define UART_REG_TR   5'd0
`define UART_REG_RB   5'd0
`define UART_REG_IE   5'd1
`define UART_REG_II   5'd2
`define UART_REG_FC   5'd2
`define UART_REG_LC   5'd3
`define UART_REG_MC   5'd4
`define UART_REG_LS   5'd5
`define UART_REG_MS   5'd6
`define UART_REG_DBG1 5'd8
`define UART_REG_DBG2 5'd12

// AXI response codes
`define UART_RESP_OKAY   2'b00
`define UART_RESP_SLVERR 2'b10

`endif

// ==== uart_pkg.sv ====
// shared types of the UART register interface
// bus vectors, byte, strobe, response and the bus FSM states
`include "uart_consts.svh"

package uart_pkg;

	// bus side vectors
	typedef logic [`UART_ADDR_W-1:0] uart_addr_t;
	typedef logic [`UART_DATA_W-1:0] uart_word_t;
	typedef logic [`UART_DATA_W/8-1:0] uart_strb_t;
	typedef logic [1:0] uart_resp_t;

	// one register or FIFO entry
	typedef logic [7:0] uart_byte_t;

	// write channel FSM
	typedef enum logic {
		wr_collect,
		wr_respond
	} wr_state_t;

	// read channel FSM
	typedef enum logic {
		rd_idle,
		rd_respond
	} rd_state_t;

endpackage

// ==== uart_byte_fifo.sv ====
// synchronous byte FIFO with occupancy count, full and empty flags
// and a sticky overflow bit
`include "uart_consts.svh"

module uart_byte_fifo #(
	parameter int depth = `UART_FIFO_DEPTH
) (
	input  logic                 s_axi_aclk,
	input  logic                 s_axi_aresetn,
	input  logic                 clear,
	input  logic                 push,
	input  uart_pkg::uart_byte_t push_byte,
	input  logic                 pop,
	output uart_pkg::uart_byte_t head,
	output logic [4:0]           count,
	output logic                 empty,
	output logic                 full,
	output logic                 overflow,
	input  logic                 overflow_clr
);
	import uart_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	uart_byte_t       mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [4:0]       occ;
	logic             do_push;
	logic             do_pop;

	// pushes into a full buffer are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (occ == 5'd0);
	assign full  = (occ == 5'(depth));
	assign count = occ;
	assign head  = mem[rd_ptr];

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			occ      <= '0;
			overflow <= 1'b0;
		end else if (clear) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			occ      <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				occ <= occ + 5'd1;
			else if (do_pop && !do_push)
				occ <= occ - 5'd1;
			// sticky until cleared, a new overflow wins
			if (push && full)
				overflow <= 1'b1;
			else if (overflow_clr)
				overflow <= 1'b0;
		end
	end

	always_ff @(posedge s_axi_aclk) begin
		if (do_push)
			mem[wr_ptr] <= push_byte;
	end

endmodule

// ==== uart_regs.sv ====
// UART register file: IE, LC, FC and MC storage, derived LS, II and MS,
// debug words and the push/pop/clear strobes toward both FIFOs
`include "uart_consts.svh"

module uart_regs (
	input  logic                 s_axi_aclk,
	input  logic                 s_axi_aresetn,
	input  uart_pkg::uart_addr_t addr,
	input  logic                 we,
	input  uart_pkg::uart_byte_t wbyte,
	input  logic                 re,
	output uart_pkg::uart_word_t rdata,
	output logic                 tx_full,
	// tx FIFO side
	output logic                 tx_push,
	output uart_pkg::uart_byte_t tx_push_byte,
	output logic                 tx_clear,
	input  logic [4:0]           tx_count,
	input  logic                 tx_empty,
	// rx FIFO side
	output logic                 rx_pop,
	output logic                 rx_clear,
	input  uart_pkg::uart_byte_t rx_head,
	input  logic [4:0]           rx_count,
	input  logic                 rx_empty,
	input  logic                 rx_overflow,
	output logic                 rx_overflow_clr,
	// modem lines
	input  logic [3:0]           modem_in
);
	import uart_pkg::*;

	logic [3:0] ie;
	uart_byte_t lc;
	logic [1:0] fc_trig;
	logic [4:0] mc;
	uart_byte_t ls;
	uart_byte_t ii;
	uart_byte_t ms;
	logic       pend_rx;
	logic       pend_tx;
	logic [2:0] int_id;

	////////////////////
	// writable registers
	////////////////////

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			ie      <= '0;
			lc      <= '0;
			fc_trig <= '0;
			mc      <= '0;
		end else if (we) begin
			case (addr)
				`UART_REG_IE: ie      <= wbyte[3:0];
				`UART_REG_LC: lc      <= wbyte;
				`UART_REG_FC: fc_trig <= wbyte[7:6];
				`UART_REG_MC: mc      <= wbyte[4:0];
				default: ;
			endcase
		end
	end

	////////////////////
	// FIFO strobes
	////////////////////

	assign tx_push      = we && (addr == `UART_REG_TR);
	assign tx_push_byte = wbyte;
	assign tx_full      = (tx_count >= 5'(`UART_FIFO_DEPTH));

	// FC bit 1 flushes rx, bit 2 flushes tx
	assign rx_clear = we && (addr == `UART_REG_FC) && wbyte[1];
	assign tx_clear = we && (addr == `UART_REG_FC) && wbyte[2];

	assign rx_pop          = re && (addr == `UART_REG_RB);
	// reading LS acknowledges the overrun
	assign rx_overflow_clr = re && (addr == `UART_REG_LS);

	////////////////////
	// derived registers
	////////////////////

	assign ls = {2'b00, tx_empty, 3'b000, rx_overflow, !rx_empty};
	assign ms = {4'b0000, modem_in};

	assign pend_rx = ie[0] && !rx_empty;
	assign pend_tx = ie[1] && tx_empty;

	// rx data has priority over tx empty
	assign int_id = pend_rx ? 3'd2 : (pend_tx ? 3'd1 : 3'd0);
	// trigger level echoed in the top bits
	assign ii = {fc_trig, 2'b00, int_id, !(pend_rx || pend_tx)};

	always_comb begin
		case (addr)
			`UART_REG_RB:   rdata = {24'd0, rx_head};
			`UART_REG_IE:   rdata = {28'd0, ie};
			`UART_REG_II:   rdata = {24'd0, ii};
			`UART_REG_LC:   rdata = {24'd0, lc};
			`UART_REG_LS:   rdata = {24'd0, ls};
			`UART_REG_MS:   rdata = {24'd0, ms};
			`UART_REG_DBG1: rdata = {lc, 4'b0000, ie, 3'b000, mc, ls};
			`UART_REG_DBG2: rdata = {16'd0, 3'b000, tx_count, 3'b000, rx_count};
			default:        rdata = '0;
		endcase
	end

endmodule

// ==== axi4lite_slave.sv ====
// AXI4-Lite slave toward the UART registers
// write and read FSMs, access checks, response and read data registers
// and byte lane selection from the one-hot strobe
`include "uart_consts.svh"

module axi4lite_slave (
	input  logic                 s_axi_aclk,
	input  logic                 s_axi_aresetn,
	// write address channel
	input  logic                 s_axi_awvalid,
	output logic                 s_axi_awready,
	input  uart_pkg::uart_addr_t s_axi_awaddr,
	input  logic [2:0]           s_axi_awprot,
	// write data channel
	input  logic                 s_axi_wvalid,
	output logic                 s_axi_wready,
	input  uart_pkg::uart_word_t s_axi_wdata,
	input  uart_pkg::uart_strb_t s_axi_wstrb,
	// write response channel
	output logic                 s_axi_bvalid,
	input  logic                 s_axi_bready,
	output uart_pkg::uart_resp_t s_axi_bresp,
	// read address channel
	input  logic                 s_axi_arvalid,
	output logic                 s_axi_arready,
	input  uart_pkg::uart_addr_t s_axi_araddr,
	input  logic [2:0]           s_axi_arprot,
	// read data channel
	output logic                 s_axi_rvalid,
	input  logic                 s_axi_rready,
	output uart_pkg::uart_word_t s_axi_rdata,
	output uart_pkg::uart_resp_t s_axi_rresp,
	// register side
	output uart_pkg::uart_addr_t addr,
	output logic                 we,
	output uart_pkg::uart_byte_t wbyte,
	output logic                 re,
	input  uart_pkg::uart_word_t rdata_in,
	input  logic                 tx_full
);
	import uart_pkg::*;

	wr_state_t  wr_state;
	rd_state_t  rd_state;
	logic       aw_got;
	logic       w_got;
	uart_addr_t aw_addr_q;
	uart_word_t wdata_q;
	uart_strb_t wstrb_q;
	logic       issue;
	logic       aw_hs;
	logic       w_hs;
	logic       ar_hs;
	logic       wr_addr_ok;
	logic       strb_onehot;
	logic       tx_overrun;
	logic       wr_ok;
	logic       rd_ok;

	////////////////////
	// write channel
	////////////////////

	// both halves held, this is the register write cycle
	assign issue = (wr_state == wr_collect) && aw_got && w_got;

	assign s_axi_awready = (wr_state == wr_collect) && !issue;
	assign s_axi_wready  = (wr_state == wr_collect) && !issue;
	assign s_axi_bvalid  = (wr_state == wr_respond);

	assign aw_hs = s_axi_awvalid && s_axi_awready;
	assign w_hs  = s_axi_wvalid && s_axi_wready;

	assign wr_addr_ok = aw_addr_q inside {`UART_REG_TR, `UART_REG_IE, `UART_REG_FC,
		`UART_REG_LC, `UART_REG_MC};
	assign strb_onehot = (wstrb_q != '0) && ((wstrb_q & (wstrb_q - 1'b1)) == '0);
	// no push into a full tx FIFO
	assign tx_overrun  = (aw_addr_q == `UART_REG_TR) && tx_full;
	assign wr_ok       = wr_addr_ok && strb_onehot && !tx_overrun;

	assign we = issue && wr_ok;

	always_comb begin
		case (wstrb_q)
			4'b0010: wbyte = wdata_q[15:8];
			4'b0100: wbyte = wdata_q[23:16];
			4'b1000: wbyte = wdata_q[31:24];
			default: wbyte = wdata_q[7:0];
		endcase
	end

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			wr_state <= wr_collect;
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
		end else begin
			case (wr_state)
				wr_collect: begin
					if (aw_hs)
						aw_got <= 1'b1;
					if (w_hs)
						w_got <= 1'b1;
					if (issue) begin
						wr_state <= wr_respond;
						aw_got   <= 1'b0;
						w_got    <= 1'b0;
					end
				end
				wr_respond: begin
					if (s_axi_bready)
						wr_state <= wr_collect;
				end
				default: wr_state <= wr_collect;
			endcase
		end
	end

	////////////////////
	// read channel
	////////////////////

	// hold off a read for the one cycle the shared address serves a write
	assign s_axi_arready = (rd_state == rd_idle) && !we;
	assign s_axi_rvalid  = (rd_state == rd_respond);
	assign ar_hs         = s_axi_arvalid && s_axi_arready;

	assign rd_ok = s_axi_araddr inside {`UART_REG_RB, `UART_REG_IE, `UART_REG_II,
		`UART_REG_LC, `UART_REG_LS, `UART_REG_MS, `UART_REG_DBG1, `UART_REG_DBG2};

	assign re   = ar_hs && rd_ok;
	assign addr = we ? aw_addr_q : s_axi_araddr;

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (ar_hs)
						rd_state <= rd_respond;
				end
				rd_respond: begin
					if (s_axi_rready)
						rd_state <= rd_idle;
				end
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// captured payload and responses
	always_ff @(posedge s_axi_aclk) begin
		if (aw_hs)
			aw_addr_q <= s_axi_awaddr;
		if (w_hs) begin
			wdata_q <= s_axi_wdata;
			wstrb_q <= s_axi_wstrb;
		end
		if (issue)
			s_axi_bresp <= wr_ok ? `UART_RESP_OKAY : `UART_RESP_SLVERR;
		if (ar_hs) begin
			// sampled before the pop that re causes
			s_axi_rdata <= rd_ok ? rdata_in : '0;
			s_axi_rresp <= rd_ok ? `UART_RESP_OKAY : `UART_RESP_SLVERR;
		end
	end

endmodule

// ==== uart_axi_top.sv ====
// UART register interface top level
// AXI4-Lite slave, register block and the tx and rx byte FIFOs
`include "uart_consts.svh"

module uart_axi_top (
	input  logic                 s_axi_aclk,
	input  logic                 s_axi_aresetn,
	input  logic                 s_axi_awvalid,
	output logic                 s_axi_awready,
	input  uart_pkg::uart_addr_t s_axi_awaddr,
	input  logic [2:0]           s_axi_awprot,
	input  logic                 s_axi_wvalid,
	output logic                 s_axi_wready,
	input  uart_pkg::uart_word_t s_axi_wdata,
	input  uart_pkg::uart_strb_t s_axi_wstrb,
	output logic                 s_axi_bvalid,
	input  logic                 s_axi_bready,
	output uart_pkg::uart_resp_t s_axi_bresp,
	input  logic                 s_axi_arvalid,
	output logic                 s_axi_arready,
	input  uart_pkg::uart_addr_t s_axi_araddr,
	input  logic [2:0]           s_axi_arprot,
	output logic                 s_axi_rvalid,
	input  logic                 s_axi_rready,
	output uart_pkg::uart_word_t s_axi_rdata,
	output uart_pkg::uart_resp_t s_axi_rresp,
	// serial side stand-in
	output uart_pkg::uart_byte_t tx_byte,
	output logic                 tx_avail,
	input  logic                 tx_take,
	input  uart_pkg::uart_byte_t rx_byte,
	input  logic                 rx_strobe,
	input  logic [3:0]           modem_in
);
	import uart_pkg::*;

	uart_addr_t reg_addr;
	logic       reg_we;
	uart_byte_t reg_wbyte;
	logic       reg_re;
	uart_word_t reg_rdata;
	logic       tx_full;
	logic       tx_push;
	uart_byte_t tx_push_byte;
	logic       tx_clear;
	logic [4:0] tx_count;
	logic       tx_empty;
	logic       rx_pop;
	logic       rx_clear;
	uart_byte_t rx_head;
	logic [4:0] rx_count;
	logic       rx_empty;
	logic       rx_overflow;
	logic       rx_overflow_clr;

	assign tx_avail = !tx_empty;

	axi4lite_slave u_slave (
		.s_axi_aclk, .s_axi_aresetn,
		.s_axi_awvalid, .s_axi_awready, .s_axi_awaddr, .s_axi_awprot,
		.s_axi_wvalid, .s_axi_wready, .s_axi_wdata, .s_axi_wstrb,
		.s_axi_bvalid, .s_axi_bready, .s_axi_bresp,
		.s_axi_arvalid, .s_axi_arready, .s_axi_araddr, .s_axi_arprot,
		.s_axi_rvalid, .s_axi_rready, .s_axi_rdata, .s_axi_rresp,
		.addr(reg_addr), .we(reg_we), .wbyte(reg_wbyte), .re(reg_re),
		.rdata_in(reg_rdata), .tx_full(tx_full)
	);

	uart_regs u_regs (
		.s_axi_aclk, .s_axi_aresetn,
		.addr(reg_addr), .we(reg_we), .wbyte(reg_wbyte), .re(reg_re),
		.rdata(reg_rdata), .tx_full(tx_full),
		.tx_push, .tx_push_byte, .tx_clear, .tx_count, .tx_empty,
		.rx_pop, .rx_clear, .rx_head, .rx_count, .rx_empty,
		.rx_overflow, .rx_overflow_clr, .modem_in
	);

	// tx overruns are refused at the bus, so its overflow stays unused
	uart_byte_fifo #(.depth(`UART_FIFO_DEPTH)) u_tx_fifo (
		.s_axi_aclk, .s_axi_aresetn,
		.clear(tx_clear), .push(tx_push), .push_byte(tx_push_byte),
		.pop(tx_take), .head(tx_byte), .count(tx_count),
		.empty(tx_empty), .full(), .overflow(), .overflow_clr(1'b0)
	);

	uart_byte_fifo #(.depth(`UART_FIFO_DEPTH)) u_rx_fifo (
		.s_axi_aclk, .s_axi_aresetn,
		.clear(rx_clear), .push(rx_strobe), .push_byte(rx_byte),
		.pop(rx_pop), .head(rx_head), .count(rx_count),
		.empty(rx_empty), .full(), .overflow(rx_overflow),
		.overflow_clr(rx_overflow_clr)
	);

endmodule

// ==== tb_uart_axi.sv ====
// testbench for the UART register interface
// stimulus table, AXI4-Lite bus tasks, serial side stand-in and checks
`include "uart_consts.svh"

module tb_uart_axi;
	import uart_pkg::*;

	localparam int op_wr = 0;
	localparam int op_rd = 1;
	localparam int op_rx = 2;
	localparam int op_tx = 3;
	localparam int max_entries = 100;

	logic s_axi_aclk, s_axi_aresetn;
	logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
	logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
	logic s_axi_rvalid, s_axi_rready;
	logic [2:0] s_axi_awprot, s_axi_arprot;
	uart_addr_t s_axi_awaddr, s_axi_araddr;
	uart_word_t s_axi_wdata, s_axi_rdata;
	uart_strb_t s_axi_wstrb;
	uart_resp_t s_axi_bresp, s_axi_rresp;
	uart_byte_t tx_byte, rx_byte;
	logic tx_avail, tx_take, rx_strobe;
	logic [3:0] modem_in;

	// stimulus table
	int         t_op   [max_entries];
	uart_addr_t t_addr [max_entries];
	uart_word_t t_data [max_entries];
	uart_strb_t t_strb [max_entries];
	uart_resp_t t_resp [max_entries];
	uart_word_t t_exp  [max_entries];
	uart_word_t t_mask [max_entries];

	int     n_entries = 0;
	int     passes = 0;
	int     fails = 0;
	int     cycles = 0;
	int     limit = 0;
	int     wr_idx = 0;
	integer seed = 32'h06a9_e6b6;

	uart_axi_top u_dut (.*);

	always #20 s_axi_aclk = ~s_axi_aclk;

	// watchdog
	always @(posedge s_axi_aclk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run passed %0d cycles without finishing", limit);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic add_entry(input int op, input uart_addr_t a, input uart_word_t d,
		input uart_strb_t s, input uart_resp_t r, input uart_word_t e, input uart_word_t m);
		t_op[n_entries]   = op;
		t_addr[n_entries] = a;
		t_data[n_entries] = d;
		t_strb[n_entries] = s;
		t_resp[n_entries] = r;
		t_exp[n_entries]  = e;
		t_mask[n_entries] = m;
		n_entries++;
	endtask

	task automatic wr_entry(input uart_addr_t a, input uart_word_t d, input uart_strb_t s,
		input uart_resp_t r);
		add_entry(op_wr, a, d, s, r, '0, '0);
	endtask

	task automatic rd_entry(input uart_addr_t a, input uart_resp_t r, input uart_word_t e,
		input uart_word_t m);
		add_entry(op_rd, a, '0, '0, r, e, m);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge s_axi_aclk);
		#5;
	endtask

	// order 0 address first, 1 data first, 2 same cycle
	task automatic axi_write(input uart_addr_t a, input uart_word_t d, input uart_strb_t s,
		input int order, output uart_resp_t resp);
		logic aw_done, w_done, aw_fire, w_fire;
		aw_done = 1'b0;
		w_done = 1'b0;
		s_axi_awaddr = a;
		s_axi_wdata = d;
		s_axi_wstrb = s;
		s_axi_awvalid = (order != 1);
		s_axi_wvalid = (order != 0);
		while (!(aw_done && w_done)) begin
			@(negedge s_axi_aclk);
			aw_fire = s_axi_awvalid && s_axi_awready;
			w_fire = s_axi_wvalid && s_axi_wready;
			wait_cycles(1);
			if (aw_fire) begin
				s_axi_awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_fire) begin
				s_axi_wvalid = 1'b0;
				w_done = 1'b1;
			end
			if (order == 0 && aw_done && !w_done)
				s_axi_wvalid = 1'b1;
			if (order == 1 && w_done && !aw_done)
				s_axi_awvalid = 1'b1;
		end
		wait_cycles($unsigned($random(seed)) % 4);
		s_axi_bready = 1'b1;
		@(negedge s_axi_aclk);
		while (!s_axi_bvalid)
			@(negedge s_axi_aclk);
		resp = s_axi_bresp;
		wait_cycles(1);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input uart_addr_t a, output uart_resp_t resp, output uart_word_t d);
		s_axi_araddr = a;
		s_axi_arvalid = 1'b1;
		@(negedge s_axi_aclk);
		while (!s_axi_arready)
			@(negedge s_axi_aclk);
		wait_cycles(1);
		s_axi_arvalid = 1'b0;
		wait_cycles($unsigned($random(seed)) % 4);
		s_axi_rready = 1'b1;
		@(negedge s_axi_aclk);
		while (!s_axi_rvalid)
			@(negedge s_axi_aclk);
		resp = s_axi_rresp;
		d = s_axi_rdata;
		wait_cycles(1);
		s_axi_rready = 1'b0;
	endtask

	// serial side stand-in
	task automatic inject_rx(input uart_byte_t b);
		rx_byte = b;
		rx_strobe = 1'b1;
		wait_cycles(1);
		rx_strobe = 1'b0;
	endtask

	task automatic take_tx(output uart_word_t d);
		@(negedge s_axi_aclk);
		while (!tx_avail)
			@(negedge s_axi_aclk);
		d = {24'd0, tx_byte};
		wait_cycles(1);
		tx_take = 1'b1;
		wait_cycles(1);
		tx_take = 1'b0;
		// bit 8 shows whether bytes still wait after the take
		d[8] = tx_avail;
	endtask

	initial begin
		uart_resp_t got_resp;
		uart_word_t got_data;
		string msg;
		s_axi_aclk = 1'b0;
		s_axi_aresetn = 1'b0;
		{s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready} = '0;
		s_axi_awprot = 3'b000;
		s_axi_arprot = 3'b000;
		s_axi_awaddr = '0;
		s_axi_araddr = '0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		tx_take = 1'b0;
		rx_strobe = 1'b0;
		rx_byte = '0;
		modem_in = 4'ha;

		////////////////////
		// register writes on each lane, then DBG1
		wr_entry(`UART_REG_IE, 32'h0000_0005, 4'b0001, `UART_RESP_OKAY);
		wr_entry(`UART_REG_LC, 32'h0000_a300, 4'b0010, `UART_RESP_OKAY);
		wr_entry(`UART_REG_MC, 32'h0015_0000, 4'b0100, `UART_RESP_OKAY);
		wr_entry(`UART_REG_IE, 32'h0900_0000, 4'b1000, `UART_RESP_OKAY);
		rd_entry(`UART_REG_DBG1, `UART_RESP_OKAY, 32'ha309_1520, 32'hffff_ffff);
		// refused accesses
		wr_entry(`UART_REG_LS, 32'h0000_0055, 4'b0001, `UART_RESP_SLVERR);
		wr_entry(`UART_REG_MS, 32'h0000_0055, 4'b0001, `UART_RESP_SLVERR);
		wr_entry(`UART_REG_DBG1, 32'h0000_0055, 4'b0001, `UART_RESP_SLVERR);
		wr_entry(`UART_REG_IE, 32'h0000_0006, 4'b0000, `UART_RESP_SLVERR);
		wr_entry(`UART_REG_LC, 32'h0000_5555, 4'b0011, `UART_RESP_SLVERR);
		rd_entry(`UART_REG_DBG1, `UART_RESP_OKAY, 32'ha309_1520, 32'hffff_ffff);
		rd_entry(5'd7, `UART_RESP_SLVERR, 32'h0, 32'hffff_ffff);
		rd_entry(5'd20, `UART_RESP_SLVERR, 32'h0, 32'hffff_ffff);
		rd_entry(`UART_REG_MS, `UART_RESP_OKAY, 32'h0000_000a, 32'hffff_ffff);
		////////////////////
		// tx path in order, LS bit 5
		wr_entry(`UART_REG_TR, 32'h0000_0011, 4'b0001, `UART_RESP_OKAY);
		wr_entry(`UART_REG_TR, 32'h2200_0000, 4'b1000, `UART_RESP_OKAY);
		wr_entry(`UART_REG_TR, 32'h0033_0000, 4'b0100, `UART_RESP_OKAY);
		rd_entry(`UART_REG_LS, `UART_RESP_OKAY, 32'h0, 32'h20);
		add_entry(op_tx, '0, '0, '0, '0, 32'h111, 32'h1ff);
		add_entry(op_tx, '0, '0, '0, '0, 32'h122, 32'h1ff);
		add_entry(op_tx, '0, '0, '0, '0, 32'h033, 32'h1ff);
		rd_entry(`UART_REG_LS, `UART_RESP_OKAY, 32'h20, 32'h20);
		// fill tx, seventeenth write refused
		for (int k = 0; k < 16; k++)
			wr_entry(`UART_REG_TR, 32'(k + 'h40) << (8 * (k % 4)), 4'(1 << (k % 4)),
				`UART_RESP_OKAY);
		wr_entry(`UART_REG_TR, 32'h0000_00ee, 4'b0001, `UART_RESP_SLVERR);
		rd_entry(`UART_REG_DBG2, `UART_RESP_OKAY, 32'h0000_1000, 32'h0000_ff00);
		wr_entry(`UART_REG_FC, 32'h0000_0004, 4'b0001, `UART_RESP_OKAY);
		rd_entry(`UART_REG_DBG2, `UART_RESP_OKAY, 32'h0, 32'h0000_ff00);
		////////////////////
		// rx path, data ready and overrun
		add_entry(op_rx, '0, 32'ha1, '0, '0, '0, '0);
		add_entry(op_rx, '0, 32'hb2, '0, '0, '0, '0);
		add_entry(op_rx, '0, 32'hc3, '0, '0, '0, '0);
		rd_entry(`UART_REG_LS, `UART_RESP_OKAY, 32'h01, 32'h01);
		rd_entry(`UART_REG_RB, `UART_RESP_OKAY, 32'ha1, 32'hff);
		rd_entry(`UART_REG_RB, `UART_RESP_OKAY, 32'hb2, 32'hff);
		rd_entry(`UART_REG_LS, `UART_RESP_OKAY, 32'h01, 32'h03);
		rd_entry(`UART_REG_RB, `UART_RESP_OKAY, 32'hc3, 32'hff);
		rd_entry(`UART_REG_LS, `UART_RESP_OKAY, 32'h00, 32'h03);
		for (int k = 0; k < 17; k++)
			add_entry(op_rx, '0, 32'(k + 'h60), '0, '0, '0, '0);
		rd_entry(`UART_REG_LS, `UART_RESP_OKAY, 32'h03, 32'h03);
		rd_entry(`UART_REG_LS, `UART_RESP_OKAY, 32'h01, 32'h03);
		rd_entry(`UART_REG_RB, `UART_RESP_OKAY, 32'h60, 32'hff);
		rd_entry(`UART_REG_RB, `UART_RESP_OKAY, 32'h61, 32'hff);
		rd_entry(`UART_REG_DBG2, `UART_RESP_OKAY, 32'h0e, 32'hff);
		wr_entry(`UART_REG_FC, 32'h0000_0200, 4'b0010, `UART_RESP_OKAY);
		rd_entry(`UART_REG_LS, `UART_RESP_OKAY, 32'h00, 32'h01);
		rd_entry(`UART_REG_DBG2, `UART_RESP_OKAY, 32'h00, 32'hff);
		////////////////////
		// interrupt identification
		add_entry(op_rx, '0, 32'h5a, '0, '0, '0, '0);
		wr_entry(`UART_REG_IE, 32'h0000_0001, 4'b0001, `UART_RESP_OKAY);
		rd_entry(`UART_REG_II, `UART_RESP_OKAY, 32'h04, 32'h0f);
		wr_entry(`UART_REG_IE, 32'h0000_0000, 4'b0100, `UART_RESP_OKAY);
		rd_entry(`UART_REG_II, `UART_RESP_OKAY, 32'h01, 32'h01);
		rd_entry(`UART_REG_RB, `UART_RESP_OKAY, 32'h5a, 32'hff);

		limit = 64 * n_entries;
		repeat (4) @(posedge s_axi_aclk);
		#5;
		s_axi_aresetn = 1'b1;
		wait_cycles(1);

		for (int i = 0; i < n_entries; i++) begin
			got_resp = `UART_RESP_OKAY;
			got_data = '0;
			msg = "";
			case (t_op[i])
				op_wr: begin
					axi_write(t_addr[i], t_data[i], t_strb[i], wr_idx % 3, got_resp);
					wr_idx++;
				end
				op_rd: axi_read(t_addr[i], got_resp, got_data);
				op_rx: inject_rx(t_data[i][7:0]);
				default: take_tx(got_data);
			endcase
			if ((t_op[i] == op_wr || t_op[i] == op_rd) && got_resp != t_resp[i])
				msg = $sformatf("response %0d, expected %0d", got_resp, t_resp[i]);
			else if ((got_data & t_mask[i]) != (t_exp[i] & t_mask[i]))
				msg = $sformatf("data %h, expected %h under mask %h", got_data,
					t_exp[i], t_mask[i]);
			if (msg.len() > 0) begin
				$display("FAILED at %0t: entry %0d op %0d addr %0d %s", $time, i, t_op[i],
					t_addr[i], msg);
				fails++;
			end else begin
				$display("entry %0d op %0d addr %0d ok", i, t_op[i], t_addr[i]);
				passes++;
			end
		end

		$display("%0d entries, %0d passed, %0d failed", n_entries, passes, fails);
		if (fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
uart_pkg.sv
uart_byte_fifo.sv
uart_regs.sv
axi4lite_slave.sv
uart_axi_top.sv
tb_uart_axi.sv

// ==== Makefile ====
# Verilator build and run of the UART register interface testbench

VERILATOR ?= verilator
TOP ?= tb_uart_axi
FLAGS ?= --binary

.PHONY: sim clean

# pass only when the run prints the pass message
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
